// ==== include/noc_macros.svh ====
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// Router geometry
`define NOC_PORTS 5
`define PORT_IDX_W 3

// Flit layout with the type field on top of the payload
`define FLIT_ID_W 3
`define LEN_W 12
`define FLIT_W (`FLIT_ID_W + `LEN_W)

// Flit type codes
`define FLIT_HEAD 3'd1
`define FLIT_BODY 3'd2
`define FLIT_TAIL 3'd3

`define FIFO_DEPTH 4

`endif

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module routerOutputTb \
  && ./obj_dir/VrouterOutputTb > sim.log 2>&1 \
  || echo "Build or run did not complete" >> sim.log
cat sim.log
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim.f ====
+incdir+include
src/nocPkg.sv
src/inputPort.sv
src/holdTimer.sv
src/outputArbiter.sv
src/linkSender.sv
src/routerOutput.sv
verif/routerOutputTb.sv

// ==== src/holdTimer.sv ====
`timescale 1ns/1ps
`include "noc_macros.svh"

module holdTimer (
  input  logic         clk,
  input  logic         rst,
  input  nocPkg::flitT headFlit,
  input  logic         run,
  output logic         timesUp
);

  nocPkg::flitIdT flitId;
  nocPkg::lenT    limit;
  nocPkg::lenT    count;

  assign flitId  = headFlit[`FLIT_W-1 -: `FLIT_ID_W];
  assign timesUp = (count == limit);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == `FLIT_HEAD && !run)
      begin
        limit <= headFlit[`LEN_W-1:0];   // Header payload is the hold length
      end
      if (!run)
      begin
        count <= '0;
      end
      else if (!timesUp)
      begin
        count <= count + 1'b1;   // Stops at the limit
      end
    end
  end

endmodule

// ==== src/inputPort.sv ====
`timescale 1ns/1ps
`include "noc_macros.svh"

module inputPort (
  input  logic         clk,
  input  logic         rst,
  input  logic         inReq,
  input  nocPkg::flitT inFlit,
  output logic         inAck,
  input  logic         pop,
  output logic         portReq,
  output nocPkg::flitT headFlit
);

  localparam int PtrW = $clog2(`FIFO_DEPTH);
  localparam int CntW = $clog2(`FIFO_DEPTH + 1);

  nocPkg::flitT    mem [`FIFO_DEPTH];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  logic            full;
  logic            push;

  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(`FIFO_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full     = (count == CntW'(`FIFO_DEPTH));
  assign push     = inReq && !inAck && !full;   // Fresh request and room left
  assign portReq  = (count != '0);
  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inAck <= 1'b0;
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
      begin
        inAck <= 1'b1;
        wrPtr <= nextPtr(wrPtr);
      end
      else if (!inReq)
      begin
        inAck <= 1'b0;   // Sender has released its request
      end
      if (pop)
      begin
        rdPtr <= nextPtr(rdPtr);
      end
      count <= count + CntW'(push) - CntW'(pop);
    end
  end

  // A push never overwrites an entry still waiting to be read
  noOverwrite: assert property (@(posedge clk) disable iff (rst)
    push |-> wrPtr != rdPtr || count == '0);

  // The link sender never pops an empty buffer
  popNotEmpty: assert property (@(posedge clk) disable iff (rst)
    pop |-> portReq);

endmodule

// ==== src/linkSender.sv ====
`timescale 1ns/1ps
`include "noc_macros.svh"

module linkSender (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NOC_PORTS-1:0] grant,
  input  logic                  grantValid,
  input  nocPkg::flitT          headFlit [`NOC_PORTS],
  output logic                  outReq,
  input  logic                  outAck,
  output nocPkg::flitT          outFlit,
  output logic [`NOC_PORTS-1:0] popPort,
  output logic                  busy
);

  typedef enum logic [1:0] {
    sendIdle,
    sendReq,
    sendRelease,
    sendPop
  } sendStateT;

  sendStateT             state;
  logic                  grantFresh;
  logic                  launch;
  logic [`NOC_PORTS-1:0] source;
  nocPkg::flitT          granted;

  always_comb
  begin
    granted = '0;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      if (grant[p])
      begin
        granted = headFlit[p];
      end
    end
  end

  // Launch only on a grant decided after the last pop
  assign launch  = (state == sendIdle) && grantFresh && grantValid;
  assign busy    = (state != sendIdle) || grantFresh;
  assign popPort = (state == sendPop) ? source : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= sendIdle;
      outReq     <= 1'b0;
      grantFresh <= 1'b0;
    end
    else
    begin
      case (state)
        sendIdle:
        begin
          grantFresh <= !grantFresh;   // Arbiter decides while low
          if (launch)
          begin
            outReq <= 1'b1;
            state  <= sendReq;
          end
        end
        sendReq:
          if (outAck)
          begin
            outReq <= 1'b0;
            state  <= sendRelease;
          end
        sendRelease:
          if (!outAck)
            state <= sendPop;
        default:
          state <= sendIdle;   // Pop pulse lasts this one cycle
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (launch)
    begin
      outFlit <= granted;
      source  <= grant;
    end
  end

  // Link flit still matches the granted head until the receiver has taken it
  outFlitStable: assert property (@(posedge clk) disable iff (rst)
    outReq |-> outFlit == granted && source == grant);

endmodule

// ==== src/nocPkg.sv ====
`include "noc_macros.svh"

package nocPkg;

  // Flit type field, header body or tail
  typedef logic [`FLIT_ID_W-1:0] flitIdT;

  // Hold length in cycles, or payload data
  typedef logic [`LEN_W-1:0] lenT;

  typedef logic [`FLIT_W-1:0] flitT;

  // Port order L N E W S from zero
  typedef logic [`PORT_IDX_W-1:0] portIdxT;

  // Grant states follow idle in port order
  typedef enum logic [2:0] {
    idle   = 3'd0,
    grantL = 3'd1,
    grantN = 3'd2,
    grantE = 3'd3,
    grantW = 3'd4,
    grantS = 3'd5
  } arbStateT;

endpackage

// ==== src/outputArbiter.sv ====
`timescale 1ns/1ps
`include "noc_macros.svh"

module outputArbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NOC_PORTS-1:0] portReq,
  input  nocPkg::flitT          headFlit [`NOC_PORTS],
  input  logic                  busy,
  output logic [`NOC_PORTS-1:0] grant,
  output logic                  grantValid
);

  nocPkg::arbStateT      state;
  nocPkg::arbStateT      nextState;
  nocPkg::portIdxT       holder;
  nocPkg::portIdxT       afterHolder;
  logic                  keepGrant;
  logic [`NOC_PORTS-1:0] run;
  logic [`NOC_PORTS-1:0] timesUp;

  function automatic nocPkg::arbStateT stateOf(input nocPkg::portIdxT idx);
    return nocPkg::arbStateT'(idx + 1'b1);
  endfunction

  // First requester at or after start, wrapping past South
  function automatic nocPkg::arbStateT firstFrom(
    input logic [`NOC_PORTS-1:0] req,
    input nocPkg::portIdxT       start
  );
    nocPkg::arbStateT pick;
    int               idx;
    pick = nocPkg::idle;
    for (int i = `NOC_PORTS - 1; i >= 0; i--)
    begin
      idx = (int'(start) + i) % `NOC_PORTS;
      if (req[idx])
      begin
        pick = stateOf(nocPkg::portIdxT'(idx));   // Nearest one wins
      end
    end
    return pick;
  endfunction

  assign holder = (state == nocPkg::idle) ? '0 : nocPkg::portIdxT'(state) - 1'b1;
  assign afterHolder = (holder == nocPkg::portIdxT'(`NOC_PORTS - 1)) ? '0 : holder + 1'b1;
  assign grantValid = (state != nocPkg::idle);

  always_comb
  begin
    grant = '0;
    if (state != nocPkg::idle)
    begin
      grant[holder] = 1'b1;
    end
  end

  always_comb
  begin
    keepGrant = 1'b0;
    run       = '0;
    nextState = state;
    if (state == nocPkg::idle)
    begin
      nextState = firstFrom(portReq, '0);
    end
    else
    begin
      keepGrant   = portReq[holder] && !timesUp[holder];
      run[holder] = busy || keepGrant;   // Count through the flit in flight
      if (!keepGrant)
      begin
        nextState = firstFrom(portReq, afterHolder);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= nocPkg::idle;
    else if (!busy)
      state <= nextState;   // Grants move only between flits
  end

  for (genvar p = 0; p < `NOC_PORTS; p++)
  begin : gTimer
    holdTimer timer (
      .clk     (clk),
      .rst     (rst),
      .headFlit(headFlit[p]),
      .run     (run[p]),
      .timesUp (timesUp[p])
    );
  end

  // Grant is one-hot exactly while a port holds the link
  grantOneHot: assert property (@(posedge clk) disable iff (rst)
    grantValid ? $onehot(grant) : grant == '0);

  // The granted port was requesting when the decision was taken
  grantHadRequest: assert property (@(posedge clk) disable iff (rst)
    grantValid && $changed(grant) |-> ($past(portReq) & grant) != '0);

endmodule

// ==== src/routerOutput.sv ====
`timescale 1ns/1ps
`include "noc_macros.svh"

module routerOutput (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NOC_PORTS-1:0] inReq,
  input  nocPkg::flitT          inFlit [`NOC_PORTS],
  output logic [`NOC_PORTS-1:0] inAck,
  output logic                  outReq,
  input  logic                  outAck,
  output nocPkg::flitT          outFlit
);

  logic [`NOC_PORTS-1:0] portReq;
  logic [`NOC_PORTS-1:0] popPort;
  logic [`NOC_PORTS-1:0] grant;
  logic                  grantValid;
  logic                  busy;
  nocPkg::flitT          headFlit [`NOC_PORTS];

  // One buffer per port in L N E W S order
  for (genvar p = 0; p < `NOC_PORTS; p++)
  begin : gPort
    inputPort inPort (
      .clk     (clk),
      .rst     (rst),
      .inReq   (inReq[p]),
      .inFlit  (inFlit[p]),
      .inAck   (inAck[p]),
      .pop     (popPort[p]),
      .portReq (portReq[p]),
      .headFlit(headFlit[p])
    );
  end

  outputArbiter arbiter (
    .clk       (clk),
    .rst       (rst),
    .portReq   (portReq),
    .headFlit  (headFlit),
    .busy      (busy),
    .grant     (grant),
    .grantValid(grantValid)
  );

  linkSender sender (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .grantValid(grantValid),
    .headFlit  (headFlit),
    .outReq    (outReq),
    .outAck    (outAck),
    .outFlit   (outFlit),
    .popPort   (popPort),
    .busy      (busy)
  );

endmodule

// ==== verif/routerOutputTb.sv ====
`timescale 1ns/1ps
`include "noc_macros.svh"

module routerOutputTb;

  // Upper bound on flits over all phases, used to size the watchdog
  localparam int MaxFlits = 95;

  logic                  clk;
  logic                  rst;
  logic [`NOC_PORTS-1:0] inReq;
  nocPkg::flitT          inFlit [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] inAck;
  logic                  outReq;
  logic                  outAck;
  nocPkg::flitT          outFlit;

  nocPkg::flitT          pending [`NOC_PORTS][$];   // Scoreboard, one queue per port
  logic [`NOC_PORTS-1:0] fullSeen;
  logic [8:0]            seqNum [`NOC_PORTS];
  int                    seed = 70;
  int                    errors = 0;
  int                    sentCount = 0;
  int                    recvCount = 0;
  int                    doneCount = 0;
  int                    soloPort = 7;   // 7 means no solo phase
  int                    lastSrc = 7;
  logic                  started = 1'b0;
  logic                  stall = 1'b0;
  logic                  rotationCheck = 1'b0;

  routerOutput uut (
    .clk   (clk),
    .rst   (rst),
    .inReq (inReq),
    .inFlit(inFlit),
    .inAck (inAck),
    .outReq(outReq),
    .outAck(outAck),
    .outFlit(outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    repeat (MaxFlits * 40 + 200) @(posedge clk);
    $display("Timeout with %0d of %0d flits received", recvCount, sentCount);
    $display("Checks failed");
    $finish;
  end

  // Header payload is a length chosen so that length mod 5 is the source
  function automatic int sourceOf(input nocPkg::flitT f);
    if (f[`FLIT_W-1 -: `FLIT_ID_W] == `FLIT_HEAD)
      return int'(f[`LEN_W-1:0]) % `NOC_PORTS;
    return int'(f[11:9]);
  endfunction

  function automatic int nextBacklogged(input int last);
    int idx;
    for (int i = 1; i <= `NOC_PORTS; i++)
    begin
      idx = (last + i) % `NOC_PORTS;
      if (pending[idx].size() != 0)
        return idx;
    end
    return 7;
  endfunction

  task automatic sendFlit(input int p, input nocPkg::flitT f);
    @(negedge clk);
    started   = 1'b1;
    inFlit[p] = f;
    inReq[p]  = 1'b1;
    while (!inAck[p])
      @(negedge clk);
    pending[p].push_back(f);   // Latched into the buffer
    sentCount++;
    fullSeen[p] = (pending[p].size() >= `FIFO_DEPTH);
    inReq[p] = 1'b0;
    while (inAck[p])
      @(negedge clk);
  endtask

  task automatic sendPacket(input int p, input int nBody, input int k);
    nocPkg::flitT f;
    f = {`FLIT_HEAD, 12'(5 * (k % 3 + 1) + p)};
    sendFlit(p, f);
    for (int b = 0; b <= nBody; b++)
    begin
      f = {(b == nBody) ? `FLIT_TAIL : `FLIT_BODY, 3'(p), seqNum[p]};
      seqNum[p] = seqNum[p] + 1'b1;
      sendFlit(p, f);
    end
  endtask

  task automatic sendStream(input int p, input int packets, input int fixedBody);
    int nBody;
    for (int k = 0; k < packets; k++)
    begin
      nBody = (fixedBody >= 0) ? fixedBody : 1 + ($random(seed) & 3);
      sendPacket(p, nBody, k + p);
    end
    doneCount++;
  endtask

  task automatic checkFlit(input nocPkg::flitT f);
    int           src;
    nocPkg::flitT expected;
    src = sourceOf(f);
    recvCount++;
    if (soloPort != 7 && src != soloPort)
    begin
      errors++;
      $display("Fail source got %h expected %h", src, soloPort);
    end
    if (src >= `NOC_PORTS || pending[src].size() == 0)
    begin
      errors++;
      $display("Received a flit that no port has pending");
      return;
    end
    if (rotationCheck && lastSrc != 7 && src != lastSrc && src != nextBacklogged(lastSrc))
    begin
      errors++;
      $display("Fail source got %h expected %h", src, nextBacklogged(lastSrc));
    end
    lastSrc  = src;
    expected = pending[src].pop_front();
    fullSeen[src] = 1'b0;
    if (f !== expected)
    begin
      errors++;
      $display("Fail outFlit got %h expected %h", f, expected);
    end
  endtask

  // Receiver side of the output link
  initial
  begin
    outAck = 1'b0;
    forever
    begin
      @(negedge clk);
      if (!rst && outReq && !outAck && !stall)
      begin
        repeat ($random(seed) & 3) @(negedge clk);
        outAck = 1'b1;
        checkFlit(outFlit);
        while (outReq)
          @(negedge clk);
        outAck = 1'b0;
      end
    end
  end

  task automatic waitDrained(input int senders);
    int busyPorts;
    busyPorts = 1;
    while (doneCount < senders || busyPorts != 0)
    begin
      @(negedge clk);
      busyPorts = 0;
      for (int p = 0; p < `NOC_PORTS; p++)
        busyPorts += pending[p].size();
    end
    repeat (10) @(negedge clk);
  endtask

  initial
  begin
    int full;
    rst      = 1'b1;
    inReq    = '0;
    fullSeen = '0;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      inFlit[p] = '0;
      seqNum[p] = '0;
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;
    repeat (8) @(negedge clk);

    soloPort = 2;   // East alone, then South alone
    sendStream(2, 1, 3);
    waitDrained(1);
    soloPort  = 4;
    doneCount = 0;
    sendStream(4, 1, 3);
    waitDrained(1);
    soloPort = 7;

    doneCount = 0;   // Mixed traffic from every port
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      automatic int q = p;
      fork
        sendStream(q, 2, -1);
      join_none
    end
    waitDrained(`NOC_PORTS);

    stall     = 1'b1;   // Receiver stops, buffers fill
    doneCount = 0;
    lastSrc   = 7;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      automatic int q = p;
      fork
        sendStream(q, 1, 3);
      join_none
    end
    full = 0;
    while (full < `NOC_PORTS)
    begin
      @(negedge clk);
      full = 0;
      for (int p = 0; p < `NOC_PORTS; p++)
        full += (pending[p].size() == `FIFO_DEPTH) ? 1 : 0;
    end
    repeat (20) @(negedge clk);
    rotationCheck = 1'b1;
    stall         = 1'b0;
    waitDrained(`NOC_PORTS);
    rotationCheck = 1'b0;

    if (recvCount != sentCount)
    begin
      errors++;
      $display("Fail recvCount got %h expected %h", recvCount, sentCount);
    end
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  // Quiet outputs until the first request
  idleAfterReset: assert property (@(posedge clk) disable iff (rst)
    !started |-> inAck == '0 && !outReq)
    else
    begin
      errors++;
      $display("Output active before any input request");
    end

  outReqAfterAck: assert property (@(posedge clk) disable iff (rst)
    $fell(outReq) |-> $past(outAck))
    else
    begin
      errors++;
      $display("outReq dropped before outAck rose");
    end

  outFlitHeld: assert property (@(posedge clk) disable iff (rst)
    outReq && $past(outReq) |-> $stable(outFlit))
    else
    begin
      errors++;
      $display("Fail outFlit got %h expected %h", outFlit, $past(outFlit));
    end

  for (genvar p = 0; p < `NOC_PORTS; p++)
  begin : gInCheck
    inFlitHeld: assert property (@(posedge clk) disable iff (rst)
      inReq[p] && $past(inReq[p]) |-> $stable(inFlit[p]))
      else
      begin
        errors++;
        $display("inFlit changed while inReq was high");
      end

    inAckAfterReq: assert property (@(posedge clk) disable iff (rst)
      $fell(inAck[p]) |-> !$past(inReq[p]))
      else
      begin
        errors++;
        $display("inAck dropped while inReq was still high");
      end

    // Back-pressure on a full buffer
    noAckWhenFull: assert property (@(posedge clk) disable iff (rst)
      $rose(inAck[p]) |-> !$past(fullSeen[p]))
      else
      begin
        errors++;
        $display("inAck rose on a full input buffer");
      end
  end

endmodule
